/* hdl/usb_bit_decode.sv */
/*
 * Finds sync and end of packet in the symbol history, decodes NRZI and
 * strips stuffed bits. Emits one rx_bit_t per cycle to the packet checker.
 */
`timescale 1ns/1ps
`include "usb_rx_cfg.svh"

module usb_bit_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  usb_line_pkg::line_sym_e line_i,
  input  logic                    sample_i,
  output usb_pkt_pkg::rx_bit_t    rx_bit_o,
  output logic                    bitstuff_err_o,
  output logic                    pkt_start_o
);

  usb_line_pkg::line_hist_t hist_q, hist_d;
  logic [2:0]               line_bits;
  logic [1:0]               sym_old, sym_new;
  logic                     se0_pair, see_sop, see_eop;
  logic                     in_packet_q, valid_q, valid_d, start_q, pkt_end;
  logic                     din, dvalid_raw, dvalid;
  logic [`USB_STUFF_RUN:0]  stuff_q;
  logic                     stuff_err_q;

  assign line_bits = line_i;

  //////////////////////
  // symbol history
  //////////////////////

  // one symbol enters per bit, always at the sample point
  assign hist_d = sample_i ? {hist_q[`USB_HIST_LEN-2:0], line_bits[1:0]} : hist_q;

  assign sym_old  = hist_q[1];
  assign sym_new  = hist_q[0];
  assign se0_pair = (hist_q[1:0] == 4'b0000);

  // start of packet is the first J to K step while the line is idle
  assign see_sop = (hist_q[1:0] == 4'b10_01) & ~in_packet_q;
  // a stuffing violation ends the packet at once, without waiting for SE0
  assign see_eop = se0_pair | stuff_err_q;

  always_comb begin
    valid_d = valid_q;
    if (sample_i) begin
      if (!valid_q && hist_q == `USB_SYNC_HIST) begin
        valid_d = 1'b1;
      end else if (valid_q && see_eop) begin
        valid_d = 1'b0;
      end
    end
  end

  assign pkt_end = valid_q & ~valid_d;

  //////////////////////
  // NRZI and unstuffing
  //////////////////////

  // no change between two bits is a one, a change is a zero
  assign din        = (sym_old == sym_new);
  assign dvalid_raw = valid_q & sample_i & (^sym_old) & (^sym_new);
  // the bit after a run of ones is the stuffed zero and is dropped
  assign dvalid     = dvalid_raw & ~(&stuff_q[`USB_STUFF_RUN-1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q      <= {`USB_HIST_LEN{usb_line_pkg::LINE_K[1:0]}};
      in_packet_q <= 1'b0;
      valid_q     <= 1'b0;
      start_q     <= 1'b0;
      stuff_q     <= '0;
      stuff_err_q <= 1'b0;
    end else begin
      hist_q <= hist_d;
      // in_packet follows the line itself, from J to K until the SE0 pair
      if (see_sop) begin
        in_packet_q <= 1'b1;
      end else if (se0_pair) begin
        in_packet_q <= 1'b0;
      end
      valid_q <= valid_d;
      start_q <= valid_d & ~valid_q;
      if (pkt_end) begin
        stuff_q <= '0;
      end else if (dvalid_raw) begin
        stuff_q <= {stuff_q[`USB_STUFF_RUN-1:0], din};
      end
      // seven ones in a row stay flagged until the next packet begins
      if (start_q) begin
        stuff_err_q <= 1'b0;
      end else if (&stuff_q) begin
        stuff_err_q <= 1'b1;
      end
    end
  end

  assign rx_bit_o.value     = din;
  assign rx_bit_o.valid     = dvalid;
  assign rx_bit_o.pkt_start = start_q;
  assign rx_bit_o.pkt_end   = pkt_end;
  assign bitstuff_err_o     = stuff_err_q;
  assign pkt_start_o        = see_sop;

endmodule

/* hdl/usb_crc_check.sv */
/*
 * Serial CRC over the bits after the PID, MSB-first register form.
 * ok_o is high while the register holds the residue of a good packet.
 */
`timescale 1ns/1ps

module usb_crc_check #(
  parameter int               Width   = 5,
  parameter logic [Width-1:0] Poly    = '0,
  parameter logic [Width-1:0] Residue = '0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic shift_i,
  input  logic bit_i,
  output logic ok_o
);

  logic [Width-1:0] crc_q;
  logic             fb;

  // feedback is the incoming bit against the register's top bit
  assign fb = bit_i ^ crc_q[Width-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= '1;
    end else if (clear_i) begin
      crc_q <= '1;
    end else if (shift_i) begin
      crc_q <= {crc_q[Width-2:0], 1'b0} ^ ({Width{fb}} & Poly);
    end
  end

  assign ok_o = (crc_q == Residue);

endmodule

/* hdl/usb_field_shift.sv */
/*
 * Collects one field of any packed type, LSB first, behind a sentinel bit.
 * done_o rises once the sentinel reaches bit 0; with Rearm it reloads next cycle.
 */
`timescale 1ns/1ps

module usb_field_shift #(
  parameter type field_t = logic [7:0],
  parameter bit  Rearm   = 1'b0
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   clear_i,
  input  logic   shift_i,
  input  logic   bit_i,
  output field_t field_o,
  output logic   done_o
);

  localparam int W = $bits(field_t);

  // the extra top bit is the sentinel, it walks down as bits come in
  logic [W:0] sr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sr_q <= '0;
    end else if (clear_i || (Rearm && done_o)) begin
      sr_q <= {1'b1, {W{1'b0}}};
    end else if (shift_i && !done_o) begin
      sr_q <= {bit_i, sr_q[W:1]};
    end
  end

  assign done_o  = sr_q[0];
  assign field_o = field_t'(sr_q[W:1]);

endmodule

/* hdl/usb_fs_rx.sv */
/*
 * Full-speed USB packet receiver, clocked at four times the bit rate.
 * Chains line recovery, bit decode and packet check; no handshake on outputs.
 */
`timescale 1ns/1ps

module usb_fs_rx (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     usb_dp_i,
  input  logic                     usb_dn_i,
  output logic                     bit_strobe_o,
  output logic                     pkt_start_o,
  output logic                     pkt_end_o,
  output logic                     rx_data_put_o,
  output usb_pkt_pkg::pid_e        pid_o,
  output usb_pkt_pkg::token_t      token_o,
  output usb_pkt_pkg::data_byte_t  rx_data_o,
  output usb_pkt_pkg::pkt_status_t status_o
);

  usb_line_pkg::line_sym_e line;
  logic                    sample;
  usb_pkt_pkg::rx_bit_t    rx_bit;
  logic                    bitstuff_err;

  // raw pair to line symbols and mid-bit sample points
  usb_line_recover u_line_recover (
    .clk_i, .rst_ni, .usb_dp_i, .usb_dn_i,
    .line_o(line), .sample_o(sample), .bit_strobe_o
  );

  // symbols to unstuffed bits with packet framing
  usb_bit_decode u_bit_decode (
    .clk_i, .rst_ni, .line_i(line), .sample_i(sample),
    .rx_bit_o(rx_bit), .bitstuff_err_o(bitstuff_err), .pkt_start_o
  );

  // bits to fields, data bytes and packet status
  usb_pkt_check u_pkt_check (
    .clk_i, .rst_ni, .rx_bit_i(rx_bit), .bitstuff_err_i(bitstuff_err),
    .pid_o, .token_o, .rx_data_o, .rx_data_put_o, .status_o
  );

  assign pkt_end_o = rx_bit.pkt_end;

endmodule

/* hdl/usb_line_pkg.sv */
/*
 * Line-level types shared by the line recovery and the bit decoder.
 */
`include "usb_rx_cfg.svh"

package usb_line_pkg;

  // recovered state of the D+/D- pair, bit 2 marks the one-sample transition
  typedef enum logic [2:0] {
    LINE_SE0 = 3'b000,
    LINE_K   = 3'b001,
    LINE_J   = 3'b010,
    LINE_DT  = 3'b100
  } line_sym_e;

  // symbols taken at the bit sample points, index 0 is the newest
  // each entry holds the lower two bits of a line_sym_e
  typedef logic [`USB_HIST_LEN-1:0][1:0] line_hist_t;

endpackage

/* hdl/usb_line_recover.sv */
/*
 * Turns the raw D+/D- samples into a line symbol and recovers the bit clock.
 * sample_o marks the mid-bit point, bit_strobe_o follows it by one cycle.
 */
`timescale 1ns/1ps
`include "usb_rx_cfg.svh"

module usb_line_recover (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  usb_dp_i,
  input  logic                  usb_dn_i,
  output usb_line_pkg::line_sym_e line_o,
  output logic                  sample_o,
  output logic                  bit_strobe_o
);

  localparam int PhaseW = $clog2(`USB_OVERSAMPLE);

  logic [1:0]              pair;
  usb_line_pkg::line_sym_e line_q, line_d;
  logic [PhaseW-1:0]       phase_q;
  logic                    strobe_q;

  assign pair = {usb_dp_i, usb_dn_i};

  //////////////////////
  // line state
  //////////////////////

  // the two wires of the pair may switch one sample apart, so any change first
  // parks in the transition state and the pair is read again one cycle later
  always_comb begin
    line_d = line_q;
    if (line_q == usb_line_pkg::LINE_DT) begin
      line_d = usb_line_pkg::line_sym_e'({1'b0, pair});
    end else if (pair != line_q[1:0]) begin
      line_d = usb_line_pkg::LINE_DT;
    end
  end

  //////////////////////
  // clock recovery
  //////////////////////

  // every transition realigns the phase, so phase 1 lands near the bit centre
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q   <= usb_line_pkg::LINE_SE0;
      phase_q  <= '0;
      strobe_q <= 1'b0;
    end else begin
      line_q   <= line_d;
      phase_q  <= (line_q == usb_line_pkg::LINE_DT) ? '0 : phase_q + PhaseW'(1);
      strobe_q <= sample_o;
    end
  end

  assign line_o       = line_q;
  assign sample_o     = (phase_q == PhaseW'(1));
  assign bit_strobe_o = strobe_q;

endmodule

/* hdl/usb_pkt_check.sv */
/*
 * Captures PID, token and data fields from the unstuffed bit stream and
 * judges PID, length and CRC. Errors pulse with the packet end.
 */
`timescale 1ns/1ps
`include "usb_rx_cfg.svh"

module usb_pkt_check (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  usb_pkt_pkg::rx_bit_t     rx_bit_i,
  input  logic                     bitstuff_err_i,
  output usb_pkt_pkg::pid_e        pid_o,
  output usb_pkt_pkg::token_t      token_o,
  output usb_pkt_pkg::data_byte_t  rx_data_o,
  output logic                     rx_data_put_o,
  output usb_pkt_pkg::pkt_status_t status_o
);

  usb_pkt_pkg::pid_field_t pid_field;
  usb_pkt_pkg::token_t     tok_field, token_q;
  logic [3:0]              pid_bits;
  logic                    pid_done, pid_ok, pay_shift, tok_done;
  logic                    is_token, is_data, is_hs, crc5_ok, crc16_ok;
  logic [3:0]              len_q;
  logic                    len16_q, len_tok, len_data, len_hs;

  // the PID comes first, every later bit is payload
  usb_field_shift #(.field_t(usb_pkt_pkg::pid_field_t)) u_pid_shift (
    .clk_i, .rst_ni, .clear_i(rx_bit_i.pkt_start), .shift_i(rx_bit_i.valid),
    .bit_i(rx_bit_i.value), .field_o(pid_field), .done_o(pid_done)
  );

  assign pid_bits  = pid_field.pid;
  assign pid_ok    = pid_done & (pid_field.pid_chk == ~pid_bits);
  assign pay_shift = rx_bit_i.valid & pid_done;
  // the two low PID bits give the packet class
  assign is_token  = (pid_bits[1:0] == 2'b01);
  assign is_data   = (pid_bits[1:0] == 2'b11);
  assign is_hs     = (pid_bits[1:0] == 2'b10);

  usb_crc_check #(.Width(5), .Poly(`USB_CRC5_POLY), .Residue(`USB_CRC5_RESIDUE)) u_crc5 (
    .clk_i, .rst_ni, .clear_i(rx_bit_i.pkt_start), .shift_i(pay_shift),
    .bit_i(rx_bit_i.value), .ok_o(crc5_ok)
  );

  usb_crc_check #(.Width(16), .Poly(`USB_CRC16_POLY), .Residue(`USB_CRC16_RESIDUE)) u_crc16 (
    .clk_i, .rst_ni, .clear_i(rx_bit_i.pkt_start), .shift_i(pay_shift),
    .bit_i(rx_bit_i.value), .ok_o(crc16_ok)
  );

  usb_field_shift #(.field_t(usb_pkt_pkg::token_t)) u_tok_shift (
    .clk_i, .rst_ni, .clear_i(rx_bit_i.pkt_start), .shift_i(pay_shift & is_token),
    .bit_i(rx_bit_i.value), .field_o(tok_field), .done_o(tok_done)
  );

  // rearms after each byte, so done is a one-cycle put strobe
  usb_field_shift #(.field_t(usb_pkt_pkg::data_byte_t), .Rearm(1'b1)) u_data_shift (
    .clk_i, .rst_ni, .clear_i(rx_bit_i.pkt_start), .shift_i(pay_shift & is_data),
    .bit_i(rx_bit_i.value), .field_o(rx_data_o), .done_o(rx_data_put_o)
  );

  // payload bit count, len16 sticks once sixteen bits have passed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q   <= '0;
      len16_q <= 1'b0;
    end else if (rx_bit_i.pkt_start) begin
      len_q   <= '0;
      len16_q <= 1'b0;
    end else if (pay_shift) begin
      len_q   <= len_q + 4'd1;
      len16_q <= len16_q | (&len_q);
    end
  end

  // token fields change only once all eleven bits are in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      token_q <= '0;
    end else if (tok_done) begin
      token_q <= tok_field;
    end
  end

  assign len_tok  = len16_q & ~|len_q;
  assign len_data = len16_q & ~|len_q[2:0];
  assign len_hs   = ~|{len16_q, len_q};

  assign pid_o   = pid_field.pid;
  assign token_o = token_q;

  assign status_o.valid_pid      = pid_ok;
  assign status_o.valid_packet   = pid_ok & ~bitstuff_err_i &
                                   ((is_hs & len_hs) | (is_data & len_data & crc16_ok) |
                                    (is_token & len_tok & crc5_ok));
  assign status_o.crc5_error     = rx_bit_i.pkt_end & is_token & ~crc5_ok;
  assign status_o.crc16_error    = rx_bit_i.pkt_end & is_data & ~crc16_ok;
  assign status_o.pid_error      = rx_bit_i.pkt_end & ~pid_ok;
  assign status_o.bitstuff_error = rx_bit_i.pkt_end & bitstuff_err_i;

endmodule

/* hdl/usb_pkt_pkg.sv */
/*
 * Packet-level types of the receiver: PID codes, captured fields,
 * the decoded bit stream between bit decoder and packet checker, and status.
 */
package usb_pkt_pkg;

  // all sixteen codes are listed so that any received nibble is a legal value
  typedef enum logic [3:0] {
    PID_RSVD  = 4'b0000, PID_OUT   = 4'b0001, PID_ACK   = 4'b0010, PID_DATA0 = 4'b0011,
    PID_PING  = 4'b0100, PID_SOF   = 4'b0101, PID_NYET  = 4'b0110, PID_DATA2 = 4'b0111,
    PID_SPLIT = 4'b1000, PID_IN    = 4'b1001, PID_NAK   = 4'b1010, PID_DATA1 = 4'b1011,
    PID_PRE   = 4'b1100, PID_SETUP = 4'b1101, PID_STALL = 4'b1110, PID_MDATA = 4'b1111
  } pid_e;

  // the PID travels first on the wire, so it sits in the low nibble
  typedef struct packed {
    logic [3:0] pid_chk;
    pid_e       pid;
  } pid_field_t;

  // an SOF frame number is the same eleven bits read as one value
  typedef struct packed {
    logic [3:0] endp;
    logic [6:0] addr;
  } token_t;

  typedef logic [7:0] data_byte_t;

  // one entry per clock from the bit decoder, valid marks an unstuffed bit
  typedef struct packed {
    logic value;
    logic valid;
    logic pkt_start;
    logic pkt_end;
  } rx_bit_t;

  // valid flags are levels, the error flags pulse with the packet end
  typedef struct packed {
    logic valid_pid;
    logic valid_packet;
    logic crc5_error;
    logic crc16_error;
    logic pid_error;
    logic bitstuff_error;
  } pkt_status_t;

endpackage

/* hdl/usb_rx_cfg.svh */
/*
 * Build-time constants of the full-speed USB receiver.
 * Include this where line timing, stuffing, CRC or sync values are needed.
 */
`ifndef USB_RX_CFG_SVH
`define USB_RX_CFG_SVH

// receiver clock cycles per USB bit, 48 MHz against 12 Mbit/s
`define USB_OVERSAMPLE 4

// number of two-bit line symbols kept in the history shift register
`define USB_HIST_LEN 6

// a zero is stuffed after this many consecutive ones
`define USB_STUFF_RUN 6

// CRC5 for tokens, x^5 + x^2 + 1, and the remainder of a good packet
`define USB_CRC5_POLY 5'b00101
`define USB_CRC5_RESIDUE 5'b01100

// CRC16 for data packets, x^16 + x^15 + x^2 + 1, and its good remainder
`define USB_CRC16_POLY 16'b1000_0000_0000_0101
`define USB_CRC16_RESIDUE 16'b1000_0000_0000_1101

// tail of the sync pattern as seen in the history, K J K J K K, oldest first
`define USB_SYNC_HIST 12'b01_10_01_10_01_01

`endif

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it into sim.log and judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module usb_fs_rx_tb -f tb.f -o usb_fs_rx_sim

./obj_dir/usb_fs_rx_sim 2>&1 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
  exit 1
fi
grep -qF '** PASS **' sim.log

/* tb.f */
+incdir+hdl
hdl/usb_line_pkg.sv
hdl/usb_pkt_pkg.sv
hdl/usb_field_shift.sv
hdl/usb_crc_check.sv
hdl/usb_line_recover.sv
hdl/usb_bit_decode.sv
hdl/usb_pkt_check.sv
hdl/usb_fs_rx.sv
verification/usb_fs_rx_chk.sv
verification/usb_fs_rx_tb.sv

/* verification/usb_fs_rx_chk.sv */
/*
 * Protocol checker bound into the receiver top level.
 * Watches error pulses, data strobes and the valid flag on the DUT ports.
 */
`timescale 1ns/1ps

module usb_fs_rx_chk (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     pkt_start_i,
  input logic                     pkt_end_i,
  input logic                     rx_data_put_i,
  input usb_pkt_pkg::pid_e        pid_i,
  input usb_pkt_pkg::pkt_status_t status_i
);

  logic in_pkt_q;
  logic err_any;
  logic judge_err;

  // the line-level start opens a packet, the decoder's end closes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_pkt_q <= 1'b0;
    end else if (pkt_start_i) begin
      in_pkt_q <= 1'b1;
    end else if (pkt_end_i) begin
      in_pkt_q <= 1'b0;
    end
  end

  assign err_any   = status_i.crc5_error | status_i.crc16_error | status_i.pid_error |
                     status_i.bitstuff_error;
  assign judge_err = status_i.crc5_error | status_i.crc16_error | status_i.pid_error;

  a_err_with_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                   err_any |-> pkt_end_i)
    else $error("an error flag pulsed away from the packet end");

  // data PIDs all have 11 in the two low bits
  a_put_in_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  rx_data_put_i |-> (in_pkt_q && pid_i[1:0] == 2'b11))
    else $error("a data byte was strobed outside a data packet");

  a_err_not_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                    judge_err |-> !status_i.valid_packet)
    else $error("a packet with a CRC or PID error was marked valid");

endmodule

bind usb_fs_rx usb_fs_rx_chk chk_inst (
  .clk_i(clk_i), .rst_ni(rst_ni), .pkt_start_i(pkt_start_o), .pkt_end_i(pkt_end_o),
  .rx_data_put_i(rx_data_put_o), .pid_i(pid_o), .status_i(status_o)
);

/* verification/usb_fs_rx_tb.sv */
/*
 * Testbench of the full-speed USB receiver. Encodes packets onto D+/D- at four
 * clocks per bit and checks PID, token, status and data with concurrent assertions.
 */
`timescale 1ns/1ps

module usb_fs_rx_tb;

  localparam logic [1:0] LineJ   = 2'b10;
  localparam logic [1:0] LineK   = 2'b01;
  localparam logic [1:0] LineSe0 = 2'b00;
  localparam int         MaxWait = 4000;

  logic clk, rst_n, usb_dp, usb_dn;
  logic bit_strobe, pkt_start, pkt_end, rx_data_put;
  usb_pkt_pkg::pid_e        pid;
  usb_pkt_pkg::token_t      token;
  usb_pkt_pkg::data_byte_t  rx_data;
  usb_pkt_pkg::pkt_status_t status;

  // expected values, written by the encoder before each packet goes out
  usb_pkt_pkg::pid_e        exp_pid;
  usb_pkt_pkg::token_t      exp_token;
  usb_pkt_pkg::pkt_status_t exp_status;
  logic       tok_chk, early_end, se0_sent;
  logic [7:0] exp_data [0:63];
  logic [7:0] exp_byte;
  int         exp_wr = 0;
  int         put_idx = 0;
  int         end_cnt = 0;
  int         start_cnt = 0;
  int         strobe_gap = 0;
  int         err_cnt = 0;
  int         timeout_cnt = 0;
  int         seed;
  logic       bits [$];

  usb_fs_rx usb_fs_rx_inst (
    .clk_i(clk), .rst_ni(rst_n), .usb_dp_i(usb_dp), .usb_dn_i(usb_dn),
    .bit_strobe_o(bit_strobe), .pkt_start_o(pkt_start), .pkt_end_o(pkt_end),
    .rx_data_put_o(rx_data_put), .pid_o(pid), .token_o(token), .rx_data_o(rx_data),
    .status_o(status)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // bytes, packet starts, packet ends and cycles between bit strobes are counted
  always @(posedge clk) begin
    if (rx_data_put) put_idx <= put_idx + 1;
    if (pkt_end) end_cnt <= end_cnt + 1;
    if (pkt_start) start_cnt <= start_cnt + 1;
    strobe_gap <= bit_strobe ? 0 : strobe_gap + 1;
  end

  assign exp_byte = exp_data[put_idx];

  //////////////////////
  // value assertions
  //////////////////////

  a_pid: assert property (@(posedge clk) disable iff (!rst_n) pkt_end |-> pid == exp_pid)
    else begin
      err_cnt++;
      $display("ERR %0t pid_o exp %h got %h", $time, exp_pid, $sampled(pid));
    end

  a_token: assert property (@(posedge clk) disable iff (!rst_n)
                            (pkt_end && tok_chk) |-> token == exp_token)
    else begin
      err_cnt++;
      $display("ERR %0t token_o exp %h got %h", $time, exp_token, $sampled(token));
    end

  a_status: assert property (@(posedge clk) disable iff (!rst_n) pkt_end |-> status == exp_status)
    else begin
      err_cnt++;
      $display("ERR %0t status_o exp %b got %b", $time, exp_status, $sampled(status));
    end

  // every byte strobed must be the next byte the encoder sent
  a_data: assert property (@(posedge clk) disable iff (!rst_n)
                           rx_data_put |-> (put_idx < exp_wr && rx_data == exp_byte))
    else begin
      err_cnt++;
      $display("ERR %0t rx_data_o exp %h got %h", $time, $sampled(exp_byte), $sampled(rx_data));
    end

  a_count: assert property (@(posedge clk) disable iff (!rst_n) pkt_end |-> put_idx == exp_wr)
    else begin
      err_cnt++;
      $display("ERR %0t rx_data_put_o count exp %0d got %0d", $time, exp_wr, $sampled(put_idx));
    end

  a_early: assert property (@(posedge clk) disable iff (!rst_n)
                            (pkt_end && early_end) |-> !se0_sent)
    else begin
      err_cnt++;
      $display("packet end after a stuffing violation came only once SE0 was on the line");
    end

  // one start per packet, and no second start before the packet has ended
  a_start: assert property (@(posedge clk) disable iff (!rst_n)
                            pkt_start |-> start_cnt == end_cnt)
    else begin
      err_cnt++;
      $display("ERR %0t pkt_start_o count exp %0d got %0d", $time, end_cnt, $sampled(start_cnt));
    end

  a_start_end: assert property (@(posedge clk) disable iff (!rst_n)
                                pkt_end |-> start_cnt == end_cnt + 1)
    else begin
      err_cnt++;
      $display("ERR %0t pkt_start_o count exp %0d got %0d", $time, end_cnt + 1,
               $sampled(start_cnt));
    end

  // inside a packet the line moves on the 4-clock grid, so strobes are 4 cycles apart
  a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
                             (start_cnt != end_cnt) |-> (bit_strobe ? strobe_gap == 3 :
                                                         strobe_gap < 3))
    else begin
      err_cnt++;
      $display("ERR %0t bit_strobe_o gap exp 3 got %0d", $time, $sampled(strobe_gap));
    end

  //////////////////////
  // packet encoder
  //////////////////////

  task automatic drive_sym(input logic [1:0] s);
    @(negedge clk);
    {usb_dp, usb_dn} = s;
    repeat (3) @(negedge clk);
  endtask

  task automatic push_field(input logic [15:0] v, input int n);
    for (int i = 0; i < n; i++) bits.push_back(v[i]);
  endtask

  task automatic start_pid(input usb_pkt_pkg::pid_e p, input logic [3:0] chk);
    bits.delete();
    push_field({8'h00, chk, p}, 8);
  endtask

  task automatic push_data(input int n);
    logic [31:0] rnd;
    logic [7:0]  b;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      // two 0xFF bytes in a row force stuffed zeros onto the line
      b = (i == 2 || i == 3) ? 8'hff : rnd[7:0];
      push_field({8'h00, b}, 8);
    end
  endtask

  // USB CRC over the bits after the PID, preset to ones, sent inverted MSB first
  task automatic append_crc(input int width);
    logic [15:0] crc;
    logic [15:0] poly;
    logic        fb;
    int          n;
    n = bits.size();
    crc = 16'hffff;
    poly = (width == 5) ? 16'h0005 : 16'h8005;
    for (int i = 8; i < n; i++) begin
      fb = bits[i] ^ crc[width-1];
      crc = {crc[14:0], 1'b0} ^ (fb ? poly : 16'h0000);
    end
    for (int i = width - 1; i >= 0; i--) bits.push_back(~crc[i]);
  endtask

  // the CRC bytes pass through the data shifter as well, so they are expected too
  task automatic record_data();
    logic [7:0] b;
    for (int i = 8; i + 7 < bits.size(); i += 8) begin
      for (int j = 0; j < 8; j++) b[j] = bits[i + j];
      exp_data[exp_wr] = b;
      exp_wr++;
    end
  endtask

  task automatic set_expect(input usb_pkt_pkg::pid_e p, input logic [5:0] st,
                            input logic tok, input logic early);
    exp_pid = p;
    exp_status = st;
    tok_chk = tok;
    early_end = early;
  endtask

  // idle J, sync KJKJKJKK, NRZI with optional stuffing, then SE0 SE0 J
  task automatic send_packet(input logic stuff_en);
    logic [1:0] lvl;
    int         ones;
    se0_sent = 1'b0;
    repeat (3) drive_sym(LineJ);
    for (int i = 0; i < 8; i++) begin
      lvl = (i % 2 == 0 || i == 7) ? LineK : LineJ;
      drive_sym(lvl);
    end
    ones = 0;
    foreach (bits[i]) begin
      // a zero toggles the line, a one keeps it
      if (!bits[i]) lvl = ~lvl;
      drive_sym(lvl);
      ones = bits[i] ? ones + 1 : 0;
      if (stuff_en && ones == 6) begin
        lvl = ~lvl;
        drive_sym(lvl);
        ones = 0;
      end
    end
    se0_sent = 1'b1;
    drive_sym(LineSe0);
    drive_sym(LineSe0);
    drive_sym(LineJ);
    drive_sym(LineJ);
  endtask

  task automatic wait_end(input int target);
    int n;
    n = 0;
    while (end_cnt < target && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (end_cnt < target) begin
      timeout_cnt++;
      $display("timeout while waiting for the end of packet %0d", target);
    end
  endtask

  //////////////////////
  // stimulus
  //////////////////////

  initial begin
    logic [31:0] rnd;
    seed = 32'h9acb_f9ea;
    {usb_dp, usb_dn} = LineJ;
    rst_n = 1'b0;
    tok_chk = 1'b0;
    early_end = 1'b0;
    se0_sent = 1'b0;
    exp_pid = usb_pkt_pkg::PID_RSVD;
    exp_token = '0;
    exp_status = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // OUT token with random address and endpoint
    rnd = $random(seed);
    exp_token = rnd[10:0];
    start_pid(usb_pkt_pkg::PID_OUT, ~usb_pkt_pkg::PID_OUT);
    push_field({5'b0, exp_token}, 11);
    append_crc(5);
    set_expect(usb_pkt_pkg::PID_OUT, 6'b110000, 1'b1, 1'b0);
    send_packet(1'b1);
    wait_end(1);

    // good DATA0 packet
    start_pid(usb_pkt_pkg::PID_DATA0, ~usb_pkt_pkg::PID_DATA0);
    push_data(6);
    append_crc(16);
    record_data();
    set_expect(usb_pkt_pkg::PID_DATA0, 6'b110000, 1'b0, 1'b0);
    send_packet(1'b1);
    wait_end(2);

    // DATA0 with one CRC bit inverted
    start_pid(usb_pkt_pkg::PID_DATA0, ~usb_pkt_pkg::PID_DATA0);
    push_data(6);
    append_crc(16);
    bits[bits.size() - 3] = ~bits[bits.size() - 3];
    record_data();
    set_expect(usb_pkt_pkg::PID_DATA0, 6'b100100, 1'b0, 1'b0);
    send_packet(1'b1);
    wait_end(3);

    // IN token whose check nibble is not the complement of the PID
    rnd = $random(seed);
    start_pid(usb_pkt_pkg::PID_IN, ~usb_pkt_pkg::PID_IN ^ 4'b0100);
    push_field({5'b0, rnd[10:0]}, 11);
    append_crc(5);
    set_expect(usb_pkt_pkg::PID_IN, 6'b000010, 1'b0, 1'b0);
    send_packet(1'b1);
    wait_end(4);

    // handshake followed by a run of ones sent without stuffing
    start_pid(usb_pkt_pkg::PID_ACK, ~usb_pkt_pkg::PID_ACK);
    push_field(16'h00ff, 8);
    set_expect(usb_pkt_pkg::PID_ACK, 6'b100001, 1'b0, 1'b1);
    send_packet(1'b0);
    wait_end(5);

    // plain ACK handshake
    start_pid(usb_pkt_pkg::PID_ACK, ~usb_pkt_pkg::PID_ACK);
    set_expect(usb_pkt_pkg::PID_ACK, 6'b110000, 1'b0, 1'b0);
    send_packet(1'b1);
    wait_end(6);

    repeat (8) @(negedge clk);
    if (end_cnt != 6) begin
      err_cnt++;
      $display("the DUT ended %0d packets where 6 were sent", end_cnt);
    end
    $display("errors: %0d value, %0d timeout", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
